//--- compile.f
rtl/pcs_rx_pkg.sv
rtl/pcs_block_if.sv
rtl/rx_gearbox.sv
rtl/block_sync.sv
rtl/descrambler.sv
rtl/pcs_rx_top.sv
tb/pcs_rx_sva.sv
tb/tb_pcs_rx.sv

//--- rtl/block_sync.sv
module block_sync (
	input logic clk,
	input logic reset,
	gearbox_if.snk blk_in,
	aligned_if.src blk_out
);

	// ==================================================
	// Alignment state
	// ==================================================

	logic [pcs_rx_pkg::err_bits-1:0] err_count;
	logic [pcs_rx_pkg::window_bits-1:0] window;
	logic [pcs_rx_pkg::cooldown_bits-1:0] cooldown;
	logic bitslip;
	logic sync_good;

	// A header is legal only when it is one of the two defined codes.
	logic bad_header;

	// Error count as seen by this block; a fresh window starts from zero.
	logic [pcs_rx_pkg::err_bits-1:0] err_now;

	assign bad_header = !((blk_in.header == pcs_rx_pkg::sync_data) ||
		(blk_in.header == pcs_rx_pkg::sync_ctrl));
	assign err_now = (window == '0) ? '0 : err_count;

	assign blk_in.bitslip = bitslip;
	assign blk_out.block_sync_good = sync_good;

	always_ff @(posedge clk) begin
		if (reset) begin
			err_count <= '0;
			window <= '0;
			cooldown <= '0;
			bitslip <= 1'b0;
			sync_good <= 1'b0;
		end else begin
			// The slip request lasts a single cycle.
			bitslip <= 1'b0;

			if (blk_in.valid) begin
				if (cooldown != '0) begin
					// Blocks cut before the slip took effect are still in flight.
					// The counter wraps to zero after 255 blocks and ends the blind time.
					cooldown <= cooldown + 1'b1;
				end else if (bad_header &&
					(err_now == pcs_rx_pkg::err_bits'(pcs_rx_pkg::err_limit))) begin
					// One error too many in this window.
					// Slip by one bit and start over with a fresh window.
					bitslip <= 1'b1;
					cooldown <= pcs_rx_pkg::cooldown_bits'(1);
					window <= '0;
					err_count <= '0;
					sync_good <= 1'b0;
				end else begin
					window <= window + 1'b1;
					err_count <= err_now + pcs_rx_pkg::err_bits'(bad_header);

					// A window that stays clean up to this point means the alignment holds.
					if ((window == pcs_rx_pkg::window_bits'(pcs_rx_pkg::good_count)) &&
						(err_now == '0) && !bad_header) begin
						sync_good <= 1'b1;
					end
				end
			end
		end
	end

	// ==================================================
	// Block forwarding
	// ==================================================

	// Every block passes on one cycle later, aligned or not.
	always_ff @(posedge clk) begin
		if (reset) begin
			blk_out.valid <= 1'b0;
		end else begin
			blk_out.valid <= blk_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		blk_out.header <= blk_in.header;
		blk_out.data <= blk_in.data;
	end

endmodule

//--- rtl/descrambler.sv
module descrambler (
	input logic clk,
	input logic reset,
	aligned_if.snk blk_in,
	output logic rx_valid,
	output logic [pcs_rx_pkg::header_width-1:0] rx_header,
	output logic [pcs_rx_pkg::payload_width-1:0] rx_data,
	output logic block_sync_good
);

	// ==================================================
	// Scrambler history
	// ==================================================

	// The last 58 scrambled bits seen on the line.
	// Bit 0 is the oldest and bit 57 the most recent.
	logic [pcs_rx_pkg::scr_tap_b-1:0] history;

	// History followed by the new payload, so that bit i of the payload sits at
	// position 58 + i and its two tap bits sit 39 and 58 positions lower.
	logic [pcs_rx_pkg::payload_width+pcs_rx_pkg::scr_tap_b-1:0] stream;
	logic [pcs_rx_pkg::payload_width-1:0] plain;

	assign stream = {blk_in.data, history};

	// All 64 bits are unrolled at once, since every tap reaches back at least 39 bits.
	assign plain = blk_in.data ^
		stream[(pcs_rx_pkg::scr_tap_b - pcs_rx_pkg::scr_tap_a) +: pcs_rx_pkg::payload_width] ^
		stream[0 +: pcs_rx_pkg::payload_width];

	// The descrambler feeds back scrambled bits, so any wrong history is flushed
	// by the next block.
	always_ff @(posedge clk) begin
		if (blk_in.valid) begin
			history <= stream[pcs_rx_pkg::payload_width +: pcs_rx_pkg::scr_tap_b];
		end
	end

	// ==================================================
	// Output register
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_valid <= 1'b0;
			block_sync_good <= 1'b0;
		end else begin
			rx_valid <= blk_in.valid;
			block_sync_good <= blk_in.block_sync_good;
		end
	end

	// The sync header is never scrambled.
	always_ff @(posedge clk) begin
		rx_header <= blk_in.header;
		rx_data <= plain;
	end

endmodule

//--- rtl/pcs_block_if.sv
// Link from the gearbox to the block synchronizer.
// The sink answers with a one-cycle bitslip pulse.
interface gearbox_if;

	logic valid;
	logic [pcs_rx_pkg::header_width-1:0] header;
	logic [pcs_rx_pkg::payload_width-1:0] data;
	logic bitslip;

	modport src (output valid, output header, output data, input bitslip);
	modport snk (input valid, input header, input data, output bitslip);

endinterface

// Link from the block synchronizer to the descrambler.
// The lock flag travels alongside every block.
interface aligned_if;

	logic valid;
	logic [pcs_rx_pkg::header_width-1:0] header;
	logic [pcs_rx_pkg::payload_width-1:0] data;
	logic block_sync_good;

	modport src (output valid, output header, output data, output block_sync_good);
	modport snk (input valid, input header, input data, input block_sync_good);

endinterface

//--- rtl/pcs_rx_pkg.sv
package pcs_rx_pkg;

	// ==================================================
	// Widths
	// ==================================================

	// The SERDES delivers one 32-bit word per valid cycle.
	localparam int lane_width = 32;

	// A 64b/66b block is a two-bit sync header followed by 64 payload bits.
	localparam int payload_width = 64;
	localparam int header_width = 2;
	localparam int block_width = header_width + payload_width;

	// The gearbox buffer holds one partial block plus one full lane word.
	localparam int buf_width = block_width + lane_width;
	localparam int fill_bits = $clog2(buf_width + 1);

	// Fill level of the gearbox buffer, in bits.
	typedef logic [fill_bits-1:0] fill_t;

	// ==================================================
	// Sync headers and block synchronizer thresholds
	// ==================================================

	// Header bit 0 is received first, so the line pattern 0 then 1 marks a data block.
	localparam logic [header_width-1:0] sync_data = 2'b10;
	localparam logic [header_width-1:0] sync_ctrl = 2'b01;

	// Bad headers tolerated in one window; the next one forces a bitslip.
	localparam int err_limit = 15;
	localparam int err_bits = $clog2(err_limit + 1);

	// An 11-bit block counter gives a 2048-block error window.
	localparam int window_bits = 11;

	// Window position at which a clean window declares lock.
	localparam int good_count = 128;

	// The counter wraps after 255 blocks, which is the blind time after a slip.
	localparam int cooldown_bits = 8;

	// ==================================================
	// Scrambler polynomial 1 + x^39 + x^58
	// ==================================================

	localparam int scr_tap_a = 39;
	localparam int scr_tap_b = 58;

endpackage

//--- rtl/pcs_rx_top.sv
module pcs_rx_top (
	input logic clk,
	input logic reset,

	// Raw words from the SERDES.
	input logic lane_valid,
	input logic [pcs_rx_pkg::lane_width-1:0] lane_data,

	// Aligned and descrambled blocks.
	output logic rx_valid,
	output logic [pcs_rx_pkg::header_width-1:0] rx_header,
	output logic [pcs_rx_pkg::payload_width-1:0] rx_data,
	output logic block_sync_good
);

	// ==================================================
	// Internal links
	// ==================================================

	// Raw blocks forward, bitslip requests back.
	gearbox_if gb_link ();

	// Aligned blocks with the lock flag.
	aligned_if al_link ();

	// ==================================================
	// Receive pipeline
	// ==================================================

	// Stage 1 cuts 66-bit blocks out of the word stream.
	rx_gearbox i_gearbox (
		.clk (clk),
		.reset (reset),
		.lane_valid (lane_valid),
		.lane_data (lane_data),
		.blk (gb_link.src)
	);

	// Stage 2 checks headers and steers the gearbox until lock.
	block_sync i_block_sync (
		.clk (clk),
		.reset (reset),
		.blk_in (gb_link.snk),
		.blk_out (al_link.src)
	);

	// Stage 3 removes the scrambling from the payload.
	descrambler i_descrambler (
		.clk (clk),
		.reset (reset),
		.blk_in (al_link.snk),
		.rx_valid (rx_valid),
		.rx_header (rx_header),
		.rx_data (rx_data),
		.block_sync_good (block_sync_good)
	);

endmodule

//--- rtl/rx_gearbox.sv
module rx_gearbox (
	input logic clk,
	input logic reset,
	input logic lane_valid,
	input logic [pcs_rx_pkg::lane_width-1:0] lane_data,
	gearbox_if.src blk
);

	// ==================================================
	// Shift buffer
	// ==================================================

	// Bit 0 of the buffer is the oldest bit on the line.
	// Bits at or above the fill level hold stale data and are masked off.
	logic [pcs_rx_pkg::buf_width-1:0] buffer;
	pcs_rx_pkg::fill_t fill;

	// Buffer contents and fill after this cycle's word and slip.
	logic [pcs_rx_pkg::buf_width-1:0] merged;
	pcs_rx_pkg::fill_t merged_fill;

	// Helpers for placing the new word just above the valid bits.
	logic [pcs_rx_pkg::buf_width-1:0] keep_mask;
	logic [pcs_rx_pkg::buf_width-1:0] word_ext;

	// A full block is available for output.
	logic emit;

	always_comb begin
		keep_mask = ~({pcs_rx_pkg::buf_width{1'b1}} << fill);
		word_ext = {{(pcs_rx_pkg::buf_width - pcs_rx_pkg::lane_width){1'b0}}, lane_data};
		merged = buffer & keep_mask;
		merged_fill = fill;

		// The new word lands directly after the newest valid bit.
		if (lane_valid) begin
			merged = merged | (word_ext << fill);
			merged_fill = fill + pcs_rx_pkg::fill_t'(pcs_rx_pkg::lane_width);
		end

		// A slip throws away the oldest bit, which moves every later block boundary.
		// The slip lands before the next block is cut from the buffer.
		if (blk.bitslip && (merged_fill != '0)) begin
			merged = merged >> 1;
			merged_fill = merged_fill - 1'b1;
		end
	end

	assign emit = (merged_fill >= pcs_rx_pkg::fill_t'(pcs_rx_pkg::block_width));

	// ==================================================
	// Control state
	// ==================================================

	// The fill never exceeds 97 bits, since a block leaves as soon as 66 are present.
	always_ff @(posedge clk) begin
		if (reset) begin
			fill <= '0;
			blk.valid <= 1'b0;
		end else begin
			blk.valid <= emit;
			if (emit) begin
				fill <= merged_fill - pcs_rx_pkg::fill_t'(pcs_rx_pkg::block_width);
			end else begin
				fill <= merged_fill;
			end
		end
	end

	// Payload path.
	// The oldest 66 bits form the block: header first, then payload bit 0 upward.
	always_ff @(posedge clk) begin
		if (emit) begin
			blk.header <= merged[pcs_rx_pkg::header_width-1:0];
			blk.data <= merged[pcs_rx_pkg::header_width +: pcs_rx_pkg::payload_width];
			buffer <= merged >> pcs_rx_pkg::block_width;
		end else begin
			buffer <= merged;
		end
	end

endmodule

//--- tb/pcs_rx_sva.sv
// Assertions on the block synchronizer.
// They are bound into every block_sync instance.
module pcs_rx_sva (
	input logic clk,
	input logic reset,
	input logic bitslip,
	input logic [pcs_rx_pkg::cooldown_bits-1:0] cooldown,
	input logic sync_good
);

	// ==================================================
	// Bitslip pulse shape
	// ==================================================

	// A slip request is a single-cycle pulse.
	// The gearbox would drop two bits if it stayed high.
	slip_is_pulse: assert property (
		@(posedge clk) disable iff (reset)
		bitslip |=> !bitslip
	) else $error("bitslip held high for two cycles");

	// While the cooldown runs, headers are ignored.
	// No new slip may be requested in that time.
	no_slip_in_cooldown: assert property (
		@(posedge clk) disable iff (reset)
		(cooldown != '0) |=> !bitslip
	) else $error("bitslip raised during cooldown");

	// ==================================================
	// Lock flag
	// ==================================================

	// A slip clears lock, and lock needs a clean window afterwards.
	// So the flag cannot come straight back.
	no_lock_after_slip: assert property (
		@(posedge clk) disable iff (reset)
		bitslip |=> !$rose(sync_good)
	) else $error("lock rose right after a bitslip");

endmodule

bind block_sync pcs_rx_sva i_sva (
	.clk (clk),
	.reset (reset),
	.bitslip (bitslip),
	.cooldown (cooldown),
	.sync_good (sync_good)
);

//--- tb/tb_pcs_rx.sv
module tb_pcs_rx;

	logic clk = 1'b0;
	logic reset;
	logic lane_valid;
	logic [31:0] lane_data;
	logic rx_valid;
	logic [1:0] rx_header;
	logic [63:0] rx_data;
	logic block_sync_good;

	// Each entry is a header above a plaintext payload.
	logic [65:0] block_table [16];

	// Line bits waiting to be cut into 32-bit words, oldest first.
	logic line_bits [$];

	// Blocks queued for the serializer; filler is made when these run dry.
	logic [1:0] pend_hdr [$];
	logic [63:0] pend_data [$];
	logic pend_bad [$];

	logic [15:0] lfsr;
	logic [57:0] scr_state;
	int insert_bits;
	bit run_line;
	bit watch_lock;
	bit timed_out;
	int data_errors;
	int lock_errors;
	int timeouts;

	pcs_rx_top i_dut (
		.clk (clk),
		.reset (reset),
		.lane_valid (lane_valid),
		.lane_data (lane_data),
		.rx_valid (rx_valid),
		.rx_header (rx_header),
		.rx_data (rx_data),
		.block_sync_good (block_sync_good)
	);

	always #5 clk = ~clk;

	// ==================================================
	// Random bits and reference scrambler
	// ==================================================

	// 16-bit Galois LFSR, one step per bit taken.
	function automatic logic next_rand_bit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) lfsr = lfsr ^ 16'hB400;
		return out;
	endfunction

	function automatic logic [63:0] rand_value(input int nbits);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < nbits; i++) v[i] = next_rand_bit();
		return v;
	endfunction

	// Bit k of the state is the scrambled bit sent k+1 bits ago.
	// Each new bit is the plain bit XOR the bits 39 and 58 back.
	function automatic logic [63:0] scramble(input logic [63:0] plain);
		logic [63:0] s;
		for (int i = 0; i < 64; i++) begin
			s[i] = plain[i] ^ scr_state[38] ^ scr_state[57];
			scr_state = {scr_state[56:0], s[i]};
		end
		return s;
	endfunction

	// Filler keeps the top byte clear, so it never matches the marker.
	task automatic push_block(input logic [1:0] hdr, input logic [63:0] data, input logic bad);
		pend_hdr.push_back(hdr);
		pend_data.push_back(data);
		pend_bad.push_back(bad);
	endtask

	task automatic push_filler(input logic bad);
		logic b;
		logic [63:0] d;
		b = next_rand_bit();
		d = rand_value(64) & 64'h00FF_FFFF_FFFF_FFFF;
		push_block({b, ~b}, d, bad);
	endtask

	// ==================================================
	// Serializer
	// ==================================================

	// A corrupted header has both bits equal. Header bit 0 goes on the line first.
	task automatic serialize_next_block();
		logic [1:0] hdr;
		logic [63:0] s;
		if (pend_hdr.size() == 0) push_filler(1'b0);
		hdr = pend_hdr.pop_front();
		s = scramble(pend_data.pop_front());
		if (pend_bad.pop_front()) hdr = {hdr[0], hdr[0]};
		line_bits.push_back(hdr[0]);
		line_bits.push_back(hdr[1]);
		for (int i = 0; i < 64; i++) line_bits.push_back(s[i]);
	endtask

	function automatic logic [31:0] pop_word();
		logic [31:0] w;
		for (int i = 0; i < 32; i++) w[i] = line_bits.pop_front();
		return w;
	endfunction

	// Extra random bits ahead of a block move every later block boundary.
	always @(posedge clk) begin
		if (run_line) begin
			while (line_bits.size() < 32) begin
				if (insert_bits > 0) begin
					repeat (insert_bits) line_bits.push_back(next_rand_bit());
					insert_bits = 0;
				end else begin
					serialize_next_block();
				end
			end
			lane_valid <= 1'b1;
			lane_data <= pop_word();
		end else begin
			lane_valid <= 1'b0;
		end
	end

	// Lock must hold for as long as this flag is set.
	always @(negedge clk) begin
		if (watch_lock && !block_sync_good) begin
			$display("FAIL block_sync_good under sparse header errors: got %h expected 1",
				block_sync_good);
			lock_errors++;
			watch_lock = 1'b0;
		end
	end

	// ==================================================
	// Waits and checks
	// ==================================================

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		timeouts++;
		timed_out = 1'b1;
	endtask

	task automatic wait_lock(input logic target, input int limit, input string what);
		int n;
		n = 0;
		while ((block_sync_good !== target) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (block_sync_good !== target) report_timeout(what);
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while ((pend_hdr.size() != 0) && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (pend_hdr.size() != 0) report_timeout("the serializer to drain");
	endtask

	task automatic next_valid(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!rx_valid && (n < limit)) begin
			@(negedge clk);
			n++;
		end
		if (!rx_valid) report_timeout("the next output block");
	endtask

	task automatic compare_header(input int k);
		if (rx_header !== block_table[k][65:64]) begin
			$display("FAIL rx_header entry %0d: got %h expected %h",
				k, rx_header, block_table[k][65:64]);
			data_errors++;
		end
	endtask

	task automatic compare_block(input int k);
		compare_header(k);
		if (rx_data !== block_table[k][63:0]) begin
			$display("FAIL rx_data entry %0d: got %h expected %h",
				k, rx_data, block_table[k][63:0]);
			data_errors++;
		end
	endtask

	// The whole table is queued, then the output is searched for the marker.
	task automatic check_table();
		int n;
		for (int k = 0; k < 16; k++) begin
			push_block(block_table[k][65:64], block_table[k][63:0], 1'b0);
		end
		n = 0;
		while (!(rx_valid && (rx_data === block_table[0][63:0])) && (n < 500)) begin
			@(negedge clk);
			n++;
		end
		if (!(rx_valid && (rx_data === block_table[0][63:0]))) begin
			report_timeout("the marker block");
		end else begin
			// The search already matched the marker payload, so only its header remains.
			compare_header(0);
			for (int k = 1; k < 16 && !timed_out; k++) begin
				next_valid(10);
				if (!timed_out) compare_block(k);
			end
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================

	initial begin
		reset = 1'b1;
		lane_valid = 1'b0;
		lane_data = '0;
		lfsr = 16'd5662;
		scr_state = '1;
		insert_bits = 0;
		run_line = 1'b0;
		watch_lock = 1'b0;
		timed_out = 1'b0;
		data_errors = 0;
		lock_errors = 0;
		timeouts = 0;

		block_table[0] = {2'b10, 64'hA5C3_9E10_0F1E_2D3C};
		block_table[1] = {2'b10, 64'h0000_0000_0000_0000};
		block_table[2] = {2'b01, 64'hFFFF_FFFF_FFFF_FFFF};
		block_table[3] = {2'b10, 64'h0123_4567_89AB_CDEF};
		block_table[4] = {2'b01, 64'h1E00_0000_0000_0000};
		block_table[5] = {2'b10, 64'h5555_5555_5555_5555};
		block_table[6] = {2'b10, 64'hAAAA_AAAA_AAAA_AAAA};
		block_table[7] = {2'b01, 64'h7807_0605_0403_02FB};
		block_table[8] = {2'b10, 64'h8000_0000_0000_0001};
		block_table[9] = {2'b10, 64'hDEAD_BEEF_CAFE_F00D};
		block_table[10] = {2'b01, 64'h87FF_FFFF_FFFF_FFFD};
		block_table[11] = {2'b10, 64'h0F0F_0F0F_F0F0_F0F0};
		block_table[12] = {2'b10, 64'h3C3C_C3C3_3C3C_C3C3};
		block_table[13] = {2'b01, 64'h1E00_0000_0000_0007};
		block_table[14] = {2'b10, 64'h0000_0001_0000_0000};
		block_table[15] = {2'b10, 64'hFEDC_BA98_7654_3210};

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		// Outputs straight after reset.
		if (rx_valid !== 1'b0) begin
			$display("FAIL rx_valid after reset: got %h expected 0", rx_valid);
			data_errors++;
		end
		if (block_sync_good !== 1'b0) begin
			$display("FAIL block_sync_good after reset: got %h expected 0", block_sync_good);
			data_errors++;
		end

		// Start misaligned by 1 to 65 bits.
		insert_bits = 1 + int'(rand_value(7) % 65);
		run_line = 1'b1;
		wait_lock(1'b1, 60000, "initial lock");
		if (!timed_out) check_table();

		// 14 bad headers spread over under 600 blocks, all within one window.
		if (!timed_out) begin
			watch_lock = 1'b1;
			for (int i = 0; i < 14; i++) begin
				push_filler(1'b1);
				repeat (40) push_filler(1'b0);
			end
			wait_drain(3000);
		end
		if (!timed_out) check_table();
		watch_lock = 1'b0;

		// A burst of 16 bad headers forces loss, then the line moves.
		if (!timed_out) begin
			repeat (16) push_filler(1'b1);
			wait_lock(1'b0, 500, "loss of lock");
		end
		if (!timed_out) begin
			insert_bits = 1 + int'(rand_value(7) % 65);
			wait_lock(1'b1, 60000, "relock");
		end
		if (!timed_out) check_table();

		$display("Done: %0d value errors, %0d lock errors, %0d timeouts",
			data_errors, lock_errors, timeouts);
		if ((data_errors + lock_errors + timeouts) == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
